// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ex_unit_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ex_unit_sva.sv
module ex_unit_sva import ex_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    req_valid,
    input logic    req_ready,
    input logic    rsp_valid,
    input logic    rsp_ready,
    input ex_rsp_t rsp
);

    int pending;   // accepted, not yet answered
    int wait_cnt;  // working cycles since the last answer

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= 0;
            wait_cnt <= 0;
        end else begin
            pending <= pending + int'(req_valid && req_ready) - int'(rsp_valid && rsp_ready);
            if ((rsp_valid && rsp_ready) || pending == 0) begin
                wait_cnt <= 0;
            end else if (!(rsp_valid && !rsp_ready)) begin  // sink stalls excluded
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while held by back-pressure");

    assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("rsp_valid high right after reset");

    assert property (@(posedge clk) disable iff (reset) wait_cnt <= 40)
        else $error("request not answered within 40 cycles");

endmodule

bind ex_unit ex_unit_sva sva0 (.*);

// File: bench/ex_unit_tb.sv
module ex_unit_tb import ex_pkg::*; ();

    localparam int N_ROWS  = 47;
    localparam int TIMEOUT = N_ROWS * 40 * 100;  // 40 cycles per row

    logic    clk;
    logic    reset;
    logic    req_valid;
    ex_req_t req;
    logic    rsp_ready;
    logic    req_ready;
    logic    rsp_valid;
    ex_rsp_t rsp;

    // one row per instruction, expected values worked out by hand
    ex_op_e      op_tab  [N_ROWS];
    logic [31:0] s1_tab  [N_ROWS];
    logic [31:0] s2_tab  [N_ROWS];
    logic [31:0] res_tab [N_ROWS];
    logic        ovf_tab [N_ROWS];
    int          n_fill;

    int          expect_q [$];  // row indices in issue order
    int          pass_cnt;
    int          fail_cnt;
    logic [15:0] lfsr;

    ex_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, taps 16,14,13,11
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return out;
    endfunction

    task automatic add_row(input ex_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                           input logic [31:0] res, input logic ovf);
        op_tab[n_fill]  = op;
        s1_tab[n_fill]  = s1;
        s2_tab[n_fill]  = s2;
        res_tab[n_fill] = res;
        ovf_tab[n_fill] = ovf;
        n_fill++;
    endtask

    task automatic fill_table();
        n_fill = 0;
        add_row(OP_ADD,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 1'b0);
        add_row(OP_ADDU,  32'hffff_fffe, 32'h0000_0003, 32'h0000_0001, 1'b0);
        add_row(OP_SUB,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 1'b0);
        add_row(OP_SUBU,  32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0);
        add_row(OP_SLT,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0);
        add_row(OP_SLTU,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
        add_row(OP_AND,   32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0);
        add_row(OP_OR,    32'hf0f0_f0f0, 32'h0f00_0f00, 32'hfff0_fff0, 1'b0);
        add_row(OP_NOR,   32'h0000_ffff, 32'h00ff_0000, 32'hff00_0000, 1'b0);
        add_row(OP_XOR,   32'haaaa_aaaa, 32'hffff_0000, 32'h5555_aaaa, 1'b0);
        add_row(OP_LUI,   32'h0000_0000, 32'h0000_1234, 32'h1234_0000, 1'b0);
        add_row(OP_SLL,   32'h0000_0004, 32'h0000_00f1, 32'h0000_0f10, 1'b0);
        add_row(OP_SRL,   32'h0000_0008, 32'h8000_0000, 32'h0080_0000, 1'b0);
        add_row(OP_SRA,   32'h0000_0008, 32'h8000_0000, 32'hff80_0000, 1'b0);
        // overflow only on the trapping forms
        add_row(OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b1);
        add_row(OP_ADDU,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0);
        add_row(OP_SUB,   32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b1);
        add_row(OP_SUBU,  32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b0);
        // -3 * 7 = -21
        add_row(OP_MULT,  32'hffff_fffd, 32'h0000_0007, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffeb, 1'b0);
        add_row(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'hffff_fffe, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        // divides, HI gets remainder and LO quotient
        add_row(OP_DIV,   32'h0000_0007, 32'h0000_0002, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'h0000_0003, 1'b0);
        add_row(OP_DIV,   32'hffff_fff9, 32'h0000_0002, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'hffff_fffd, 1'b0);
        add_row(OP_DIV,   32'h0000_0007, 32'hffff_fffe, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'hffff_fffd, 1'b0);
        add_row(OP_DIV,   32'hffff_fff9, 32'hffff_fffe, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'h0000_0003, 1'b0);
        add_row(OP_DIVU,  32'hffff_fff9, 32'h0000_0002, 32'h0000_0000, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'h7fff_fffc, 1'b0);
        add_row(OP_DIV,   32'hffff_fff9, 32'h0000_0000, 32'h0000_0000, 1'b0);  // by zero
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'hffff_fff9, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 1'b0);
        add_row(OP_MTHI,  32'h1234_5678, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_row(OP_MTLO,  32'h9abc_def0, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_row(OP_ADD,   32'h0000_0001, 32'h0000_0001, 32'h0000_0002, 1'b0);
        add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 32'h1234_5678, 1'b0);
        add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 32'h9abc_def0, 1'b0);
    endtask

    task automatic check_response();
        int    idx;
        logic  bad;
        string verdict;
        bad = 1'b0;
        if (expect_q.size() == 0) begin
            $display("extra response with tag %0d at time %0t, nothing was outstanding",
                     rsp.tag, $time);
            fail_cnt++;
            return;
        end
        idx = expect_q.pop_front();
        if (rsp.tag != TAG_W'(idx)) begin
            $display("tag %0d came back at time %0t while tag %0d was due, one is missing",
                     rsp.tag, $time, TAG_W'(idx));
            bad = 1'b1;
        end
        if (rsp.result != res_tab[idx]) begin
            $display("Error at time %0t: rsp.result expected %h, got %h",
                     $time, res_tab[idx], rsp.result);
            bad = 1'b1;
        end
        if (rsp.overflow != ovf_tab[idx]) begin
            $display("Error at time %0t: rsp.overflow expected %b, got %b",
                     $time, ovf_tab[idx], rsp.overflow);
            bad = 1'b1;
        end
        if (bad) begin
            fail_cnt++;
            verdict = "failed";
        end else begin
            pass_cnt++;
            verdict = "ok";
        end
        $display("row %0d %s tag %0d %s", idx, op_tab[idx].name(), rsp.tag, verdict);
    endtask

    // driver, also owns rsp_ready so all random bits come from one process
    initial begin
        int   sent;
        logic fire;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        lfsr      = 16'd92;
        pass_cnt  = 0;
        fail_cnt  = 0;
        sent      = 0;
        fill_table();
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        while (sent < N_ROWS || expect_q.size() != 0) begin
            rsp_ready = next_bit();
            if (!req_valid && sent < N_ROWS) begin
                if (next_bit() || next_bit()) begin  // gap about one cycle in four
                    req_valid = 1'b1;
                    req = '{op: op_tab[sent], src1: s1_tab[sent], src2: s2_tab[sent],
                            tag: TAG_W'(sent)};
                end
            end
            @(negedge clk);
            fire = req_valid && req_ready;
            if (fire) begin
                expect_q.push_back(sent);
                sent++;
            end
            @(posedge clk);
            #10;
            if (fire) begin
                req_valid = 1'b0;
            end
        end
        $display("rows checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // monitor, samples mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && rsp_valid && rsp_ready) begin
                check_response();
            end
        end
    end

    initial begin
        #(TIMEOUT + 400);
        $display("watchdog expired at %0t with %0d responses still outstanding",
                 $time, expect_q.size());
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: design/alu_core.sv
module alu_core import ex_pkg::*; (
    input  ex_op_e      op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    input  logic        trap,
    output logic [31:0] result,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        add_ovf;
    logic        sub_ovf;
    logic        lt_signed;
    logic        lt_unsigned;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // same-sign operands, sum flips sign
    assign add_ovf = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    // opposite-sign operands, result sign differs from src1
    assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            OP_ADD, OP_ADDU: result = sum;
            OP_SUB, OP_SUBU: result = diff;
            OP_SLT:          result = {31'b0, lt_signed};
            OP_SLTU:         result = {31'b0, lt_unsigned};
            OP_AND:          result = src1 & src2;
            OP_OR:           result = src1 | src2;
            OP_NOR:          result = ~(src1 | src2);
            OP_XOR:          result = src1 ^ src2;
            OP_SLL:          result = src2 << src1[4:0];
            OP_SRL:          result = src2 >> src1[4:0];
            OP_SRA:          result = $signed(src2) >>> src1[4:0];
            OP_LUI:          result = {src2[15:0], 16'b0};
            default:         result = 32'b0;  // served by other units
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        if (!trap) begin
            overflow = 1'b0;
        end else if (op == OP_SUB) begin
            overflow = sub_ovf;
        end else begin
            overflow = add_ovf;
        end
    end

endmodule

// File: design/div_unit.sv
module div_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        div_start,
    input  logic        div_signed,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic        div_done,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    logic        busy_q;
    logic [4:0]  count_q;
    logic [31:0] quo_q;       // dividend bits shift out, quotient bits shift in
    logic [31:0] rem_q;
    logic [31:0] dsr_q;       // divisor magnitude
    logic        quo_neg_q;
    logic        rem_neg_q;
    logic        div_zero_q;
    logic        load;
    logic [32:0] shifted;
    logic [32:0] trial;

    assign load = div_start && !busy_q;

    // one restoring step
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            count_q  <= 5'd0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (busy_q) begin
                count_q <= count_q + 5'd1;
                if (count_q == 5'd31) begin  // last of 32 steps
                    busy_q   <= 1'b0;
                    div_done <= 1'b1;
                end
            end else if (div_start) begin
                busy_q  <= 1'b1;
                count_q <= 5'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q      <= 32'b0;
            quo_q      <= (div_signed && src1[31]) ? -src1 : src1;
            dsr_q      <= (div_signed && src2[31]) ? -src2 : src2;
            quo_neg_q  <= div_signed && (src1[31] ^ src2[31]);
            rem_neg_q  <= div_signed && src1[31];
            div_zero_q <= (src2 == 32'b0);
        end else if (busy_q) begin
            quo_q <= {quo_q[30:0], !trial[32]};
            rem_q <= trial[32] ? shifted[31:0] : trial[31:0];  // restore on borrow
        end
    end

    // remainder follows dividend sign, which also gives the dividend back on /0
    assign quotient  = div_zero_q ? 32'hffff_ffff : (quo_neg_q ? -quo_q : quo_q);
    assign remainder = rem_neg_q ? -rem_q : rem_q;

endmodule

// File: design/ex_decode.sv
module ex_decode import ex_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    input  ex_req_t req,
    input  logic    dec_ready,
    output logic    req_ready,
    output logic    dec_valid,
    output ex_dec_t dec
);

    ex_class_e cls;
    logic      trap;

    // opcode to serving unit
    always_comb begin
        case (req.op)
            OP_MULT, OP_MULTU: cls = CLS_MUL;
            OP_DIV, OP_DIVU:   cls = CLS_DIV;
            OP_MFHI, OP_MFLO,
            OP_MTHI, OP_MTLO:  cls = CLS_HILO;
            default:           cls = CLS_ALU;
        endcase
    end

    assign trap = (req.op == OP_ADD) || (req.op == OP_SUB);

    // register empty or being drained this cycle
    assign req_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (req_ready) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            dec.req  <= req;
            dec.cls  <= cls;
            dec.trap <= trap;
        end
    end

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

    localparam int TAG_W = 4;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } ex_op_e;

    // unit that serves an instruction
    typedef enum logic [1:0] {CLS_ALU, CLS_MUL, CLS_DIV, CLS_HILO} ex_class_e;

    typedef enum logic [1:0] {EX_IDLE, EX_MUL_WAIT, EX_DIV_WAIT, EX_RESP} ex_state_e;

    typedef struct packed {
        ex_op_e           op;
        logic [31:0]      src1;
        logic [31:0]      src2;
        logic [TAG_W-1:0] tag;
    } ex_req_t;

    typedef struct packed {
        ex_req_t   req;
        ex_class_e cls;
        logic      trap;  // add/sub that may raise overflow
    } ex_dec_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      result;
        logic             overflow;
    } ex_rsp_t;

endpackage

// File: design/ex_stage.sv
module ex_stage import ex_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    dec_valid,
    input  ex_dec_t dec,
    input  logic    rsp_ready,
    output logic    dec_ready,
    output logic    rsp_valid,
    output ex_rsp_t rsp
);

    ex_state_e        state;
    ex_rsp_t          rsp_q;
    logic [TAG_W-1:0] tag_q;        // tag of the mul/div in flight
    logic [31:0]      hi_q;
    logic [31:0]      lo_q;
    logic             accept;
    logic             mul_start;
    logic             div_start;
    logic             mul_done;
    logic             div_done;
    logic             mul_fin;
    logic             div_fin;
    logic [63:0]      mul_product;
    logic [31:0]      div_quo;
    logic [31:0]      div_rem;
    logic [31:0]      alu_result;
    logic             alu_overflow;
    logic [31:0]      hilo_result;

    // take a new one when idle or while the response drains
    assign dec_ready = (state == EX_IDLE) || ((state == EX_RESP) && rsp_ready);
    assign accept    = dec_valid && dec_ready;
    assign rsp_valid = (state == EX_RESP);
    assign rsp       = rsp_q;

    assign mul_start = accept && (dec.cls == CLS_MUL);
    assign div_start = accept && (dec.cls == CLS_DIV);
    assign mul_fin   = (state == EX_MUL_WAIT) && mul_done;
    assign div_fin   = (state == EX_DIV_WAIT) && div_done;

    alu_core u_alu (
        .op       (dec.req.op),
        .src1     (dec.req.src1),
        .src2     (dec.req.src2),
        .trap     (dec.trap),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
        .clk        (clk),
        .reset      (reset),
        .mul_start  (mul_start),
        .mul_signed (dec.req.op == OP_MULT),
        .src1       (dec.req.src1),
        .src2       (dec.req.src2),
        .mul_done   (mul_done),
        .product    (mul_product)
    );

    div_unit u_div (
        .clk        (clk),
        .reset      (reset),
        .div_start  (div_start),
        .div_signed (dec.req.op == OP_DIV),
        .src1       (dec.req.src1),
        .src2       (dec.req.src2),
        .div_done   (div_done),
        .quotient   (div_quo),
        .remainder  (div_rem)
    );

    // mthi/mtlo answer zero
    assign hilo_result = (dec.req.op == OP_MFHI) ? hi_q :
                         (dec.req.op == OP_MFLO) ? lo_q : 32'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EX_IDLE;
        end else if (accept) begin
            case (dec.cls)
                CLS_MUL: state <= EX_MUL_WAIT;
                CLS_DIV: state <= EX_DIV_WAIT;
                default: state <= EX_RESP;
            endcase
        end else begin
            case (state)
                EX_MUL_WAIT: if (mul_done) state <= EX_RESP;
                EX_DIV_WAIT: if (div_done) state <= EX_RESP;
                EX_RESP:     if (rsp_ready) state <= EX_IDLE;
                default:     state <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q <= dec.req.tag;
        end
        if (accept && (dec.cls == CLS_ALU)) begin
            rsp_q <= '{tag: dec.req.tag, result: alu_result, overflow: alu_overflow};
        end else if (accept && (dec.cls == CLS_HILO)) begin
            rsp_q <= '{tag: dec.req.tag, result: hilo_result, overflow: 1'b0};
        end else if (mul_fin || div_fin) begin
            rsp_q <= '{tag: tag_q, result: 32'b0, overflow: 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= 32'b0;
            lo_q <= 32'b0;
        end else if (mul_fin) begin
            hi_q <= mul_product[63:32];
            lo_q <= mul_product[31:0];
        end else if (div_fin) begin
            hi_q <= div_rem;  // remainder high, quotient low
            lo_q <= div_quo;
        end else if (accept && (dec.req.op == OP_MTHI)) begin
            hi_q <= dec.req.src1;
        end else if (accept && (dec.req.op == OP_MTLO)) begin
            lo_q <= dec.req.src1;
        end
    end

endmodule

// File: design/ex_unit.sv
module ex_unit import ex_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    input  ex_req_t req,
    input  logic    rsp_ready,
    output logic    req_ready,
    output logic    rsp_valid,
    output ex_rsp_t rsp
);

    logic    dec_valid;
    logic    dec_ready;
    ex_dec_t dec;

    // stage 1, classify and register
    ex_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .dec_ready (dec_ready),
        .req_ready (req_ready),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    ex_stage #(.MUL_STAGES(MUL_STAGES)) u_stage (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rsp_ready (rsp_ready),
        .dec_ready (dec_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// File: design/mul_unit.sv
module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mul_start,
    input  logic        mul_signed,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic        mul_done,
    output logic [63:0] product
);

    logic [31:0]           mag1;
    logic [31:0]           mag2;
    logic                  neg;
    logic [MUL_STAGES-1:0] valid_q;
    logic [MUL_STAGES-1:0] neg_q;
    logic [63:0]           prod_q [MUL_STAGES];

    // unsigned multiply on magnitudes
    assign mag1 = (mul_signed && src1[31]) ? -src1 : src1;
    assign mag2 = (mul_signed && src2[31]) ? -src2 : src2;
    assign neg  = mul_signed && (src1[31] ^ src2[31]);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q << 1) | MUL_STAGES'(mul_start);
        end
    end

    // product and sign travel alongside the valid bit
    always_ff @(posedge clk) begin
        neg_q     <= (neg_q << 1) | MUL_STAGES'(neg);
        prod_q[0] <= 64'(mag1) * 64'(mag2);
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign mul_done = valid_q[MUL_STAGES-1];

    // sign correction at the last stage
    assign product = neg_q[MUL_STAGES-1] ? -prod_q[MUL_STAGES-1] : prod_q[MUL_STAGES-1];

endmodule

// File: tb.f
design/ex_pkg.sv
design/ex_decode.sv
design/alu_core.sv
design/mul_unit.sv
design/div_unit.sv
design/ex_stage.sv
design/ex_unit.sv
bench/ex_unit_sva.sv
bench/ex_unit_tb.sv
